//--- hw/pinmux_bus_pkg.sv
/* Register bus types for the pinmux block
   Request and write-strobe structs, plus byte-lane helpers */
package pinmux_bus_pkg;

  // Widths on the native register bus
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_be_t;
  // Word index, address bits 6:2
  typedef logic [4:0]  reg_idx_t;

  // Master request as driven on the pins
  typedef struct packed {
    logic      cs;
    logic      wr;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_be_t   be;
  } reg_req_t;

  // Decoded write strobe to the register blocks
  typedef struct packed {
    // Write cycle present
    logic      wr_en;
    // Write in its ack cycle
    logic      commit;
    reg_idx_t  idx;
    reg_be_t   be;
    reg_data_t data;
  } reg_wr_t;

  // --------------------
  // Byte-lane helpers

  // Spread byte enables to a bit mask
  function automatic reg_data_t be_mask(input reg_be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Enabled lanes from din, the rest kept
  function automatic reg_data_t be_merge(input reg_data_t cur, input reg_data_t din,
                                         input reg_be_t be);
    reg_data_t m;
    m = be_mask(be);
    return (cur & ~m) | (din & m);
  endfunction

endpackage

//--- hw/pinmux_map_pkg.sv
/* Register map of the global and pin-mux block
   Word indices, field positions, interrupt widths and readback words */
package pinmux_map_pkg;

  // Mapped words, indices 0 to 13
  localparam int NUM_WORDS = 14;

  // --------------------
  // Word indices
  localparam pinmux_bus_pkg::reg_idx_t IDX_CHIP_ID    = 5'd0;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GLBL_CFG0  = 5'd1;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GLBL_CFG1  = 5'd2;
  localparam pinmux_bus_pkg::reg_idx_t IDX_INTR_MASK  = 5'd3;
  localparam pinmux_bus_pkg::reg_idx_t IDX_INTR_STAT  = 5'd4;
  // GPIO words
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_IN    = 5'd5;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_OUT   = 5'd6;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_DIR   = 5'd7;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_TYPE  = 5'd8;
  // Status, write 1 to clear
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_ISTAT = 5'd9;
  // Status alias, write 1 to set
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_ISET  = 5'd10;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_IMASK = 5'd11;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_POS   = 5'd12;
  localparam pinmux_bus_pkg::reg_idx_t IDX_GPIO_NEG   = 5'd13;

  // --------------------
  // Interrupt widths
  typedef logic [7:0]  hw_irq_t;
  typedef logic [15:0] irq_lines_t;
  typedef logic [2:0]  user_irq_t;

  // Soft resets, all active low
  typedef struct packed {
    logic [1:0] cpu_core_rst_n;
    logic       cpu_intf_rst_n;
    logic       qspim_rst_n;
    logic       sspim_rst_n;
    logic       i2cm_rst_n;
    logic       usb_rst_n;
    logic [1:0] uart_rst_n;
  } rst_ctrl_t;

  // Bit positions in configuration word 0, bit 7 spare
  localparam int CFG0_CPU_INTF_RST = 0;
  localparam int CFG0_QSPIM_RST    = 1;
  localparam int CFG0_SSPIM_RST    = 2;
  localparam int CFG0_UART0_RST    = 3;
  localparam int CFG0_I2CM_RST     = 4;
  localparam int CFG0_USB_RST      = 5;
  localparam int CFG0_UART1_RST    = 6;
  // Two bits, one per core
  localparam int CFG0_CPU_CORE_RST = 8;

  // Readback words, one slot per index
  typedef pinmux_bus_pkg::reg_data_t [NUM_WORDS-1:0] rd_words_t;

endpackage

//--- hw/pinmux_bus_front.sv
/* Register bus front end
   One-cycle ack, word decode and the write strobe to the register blocks */
`timescale 1ns/1ps

module pinmux_bus_front (
  input  logic                     mclk,
  input  logic                     h_reset_n,
  input  pinmux_bus_pkg::reg_req_t req,
  output logic                     ack,
  output pinmux_bus_pkg::reg_wr_t  wr,
  output logic                     rd_capture,
  output pinmux_bus_pkg::reg_idx_t rd_idx
);

  // Word index from the byte address
  pinmux_bus_pkg::reg_idx_t idx;

  assign idx = req.addr[6:2];

  // --------------------
  // Ack generation
  // High for one cycle, one clock after cs
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req.cs & ~ack;
    end
  end

  // --------------------
  // Write strobe
  always_comb begin
    wr.wr_en  = req.cs & req.wr;
    // Status registers act here only
    wr.commit = req.cs & req.wr & ack;
    wr.idx    = idx;
    wr.be     = req.be;
    wr.data   = req.wdata;
  end

  // Read word sampled in the cycle before ack
  assign rd_capture = req.cs & ~req.wr & ~ack;
  assign rd_idx     = idx;

endmodule

//--- hw/pinmux_glbl_regs.sv
/* Global registers
   Chip ID, soft-reset configuration and pulse/RISC-V control word */
`timescale 1ns/1ps

module pinmux_glbl_regs #(
  parameter pinmux_bus_pkg::reg_data_t CHIP_ID_WORD = 32'h8268_1301
) (
  input  logic                           mclk,
  input  logic                           h_reset_n,
  input  pinmux_bus_pkg::reg_wr_t        wr,
  output pinmux_map_pkg::rst_ctrl_t      rst_ctrl,
  output logic [9:0]                     cfg_pulse_1us,
  output logic [15:0]                    cfg_riscv_ctrl,
  output wire pinmux_map_pkg::rd_words_t rd_words
);

  // Configuration words 0 and 1
  pinmux_bus_pkg::reg_data_t cfg0;
  pinmux_bus_pkg::reg_data_t cfg1;

  // Byte-wise writes on every matching write cycle
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      cfg0 <= '0;
      cfg1 <= '0;
    end else if (wr.wr_en) begin
      if (wr.idx == pinmux_map_pkg::IDX_GLBL_CFG0) begin
        cfg0 <= pinmux_bus_pkg::be_merge(cfg0, wr.data, wr.be);
      end
      if (wr.idx == pinmux_map_pkg::IDX_GLBL_CFG1) begin
        cfg1 <= pinmux_bus_pkg::be_merge(cfg1, wr.data, wr.be);
      end
    end
  end

  // --------------------
  // Soft resets, held low until software sets them
  always_comb begin
    rst_ctrl.cpu_intf_rst_n = cfg0[pinmux_map_pkg::CFG0_CPU_INTF_RST];
    rst_ctrl.qspim_rst_n    = cfg0[pinmux_map_pkg::CFG0_QSPIM_RST];
    rst_ctrl.sspim_rst_n    = cfg0[pinmux_map_pkg::CFG0_SSPIM_RST];
    rst_ctrl.i2cm_rst_n     = cfg0[pinmux_map_pkg::CFG0_I2CM_RST];
    rst_ctrl.usb_rst_n      = cfg0[pinmux_map_pkg::CFG0_USB_RST];
    rst_ctrl.uart_rst_n     = {cfg0[pinmux_map_pkg::CFG0_UART1_RST],
                               cfg0[pinmux_map_pkg::CFG0_UART0_RST]};
    rst_ctrl.cpu_core_rst_n = cfg0[pinmux_map_pkg::CFG0_CPU_CORE_RST +: 2];
  end

  // Pulse divider low, RISC-V control high
  assign cfg_pulse_1us  = cfg1[9:0];
  assign cfg_riscv_ctrl = cfg1[31:16];

  // Readback slots of this block
  assign rd_words[pinmux_map_pkg::IDX_CHIP_ID]   = CHIP_ID_WORD;
  assign rd_words[pinmux_map_pkg::IDX_GLBL_CFG0] = cfg0;
  assign rd_words[pinmux_map_pkg::IDX_GLBL_CFG1] = cfg1;

endmodule

//--- hw/pinmux_intr_ctrl.sv
/* Global interrupt controller
   Mask and status words, latched hardware requests, masked IRQ outputs */
`timescale 1ns/1ps

module pinmux_intr_ctrl (
  input  logic                           mclk,
  input  logic                           h_reset_n,
  input  pinmux_bus_pkg::reg_wr_t        wr,
  input  pinmux_map_pkg::hw_irq_t        hw_irq,
  output pinmux_map_pkg::irq_lines_t     irq_lines,
  output logic                           soft_irq,
  output pinmux_map_pkg::user_irq_t      user_irq,
  output wire pinmux_map_pkg::rd_words_t rd_words
);

  pinmux_bus_pkg::reg_data_t intr_mask;
  pinmux_bus_pkg::reg_data_t intr_stat;
  // Status byte 0 and bits 19:16 are plain bits
  logic [7:0]                stat_b0;
  logic [3:0]                stat_b2;
  // Byte 1 holds the hardware requests
  pinmux_map_pkg::hw_irq_t   stat_b1;
  logic                      mask_wr;
  logic                      stat_wr;
  logic [7:0]                stat_clr;

  assign mask_wr = wr.wr_en & (wr.idx == pinmux_map_pkg::IDX_INTR_MASK);
  assign stat_wr = wr.wr_en & (wr.idx == pinmux_map_pkg::IDX_INTR_STAT);
  // Write-1-clear once, in the ack cycle
  assign stat_clr = (stat_wr & wr.commit & wr.be[1]) ? wr.data[15:8] : 8'h00;

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      intr_mask <= '0;
      stat_b0   <= '0;
      stat_b1   <= '0;
      stat_b2   <= '0;
    end else begin
      if (mask_wr) begin
        intr_mask <= pinmux_bus_pkg::be_merge(intr_mask, wr.data, wr.be);
      end
      if (stat_wr & wr.be[0]) begin
        stat_b0 <= wr.data[7:0];
      end
      if (stat_wr & wr.be[2]) begin
        stat_b2 <= wr.data[19:16];
      end
      // Hardware set beats software clear
      stat_b1 <= hw_irq | (stat_b1 & ~stat_clr);
    end
  end

  assign intr_stat = {12'h000, stat_b2, stat_b1, stat_b0};

  // --------------------
  // Masked outputs
  assign irq_lines = intr_stat[15:0] & intr_mask[15:0];
  assign soft_irq  = intr_stat[16] & intr_mask[16];
  assign user_irq  = intr_stat[19:17] & intr_mask[19:17];

  assign rd_words[pinmux_map_pkg::IDX_INTR_MASK] = intr_mask;
  assign rd_words[pinmux_map_pkg::IDX_INTR_STAT] = intr_stat;

endmodule

//--- hw/pinmux_gpio_regs.sv
/* GPIO registers
   Input synchroniser, pad configuration, interrupt status and mask */
`timescale 1ns/1ps

module pinmux_gpio_regs (
  input  logic                           mclk,
  input  logic                           h_reset_n,
  input  pinmux_bus_pkg::reg_wr_t        wr,
  input  pinmux_bus_pkg::reg_data_t      gpio_in_data,
  input  pinmux_bus_pkg::reg_data_t      gpio_int_event,
  output pinmux_bus_pkg::reg_data_t      cfg_gpio_data_in,
  output pinmux_bus_pkg::reg_data_t      cfg_gpio_out_data,
  output pinmux_bus_pkg::reg_data_t      cfg_gpio_dir_sel,
  output pinmux_bus_pkg::reg_data_t      cfg_gpio_out_type,
  output pinmux_bus_pkg::reg_data_t      cfg_gpio_posedge_int_sel,
  output pinmux_bus_pkg::reg_data_t      cfg_gpio_negedge_int_sel,
  output logic                           gpio_intr,
  output wire pinmux_map_pkg::rd_words_t rd_words
);

  // Synchroniser stages
  pinmux_bus_pkg::reg_data_t in_s;
  pinmux_bus_pkg::reg_data_t in_ss;
  pinmux_bus_pkg::reg_data_t data_in;
  // Configuration words
  pinmux_bus_pkg::reg_data_t out_data;
  pinmux_bus_pkg::reg_data_t dir_sel;
  pinmux_bus_pkg::reg_data_t out_type;
  pinmux_bus_pkg::reg_data_t int_mask;
  pinmux_bus_pkg::reg_data_t pos_sel;
  pinmux_bus_pkg::reg_data_t neg_sel;
  // Interrupt status and its set/clear terms
  pinmux_bus_pkg::reg_data_t int_stat;
  pinmux_bus_pkg::reg_data_t stat_set;
  pinmux_bus_pkg::reg_data_t stat_clr;
  // Write data on the enabled lanes only
  pinmux_bus_pkg::reg_data_t wr_bits;
  logic                      istat_hit;
  logic                      iset_hit;

  // --------------------
  // Pin input, three flops to the register
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      in_s    <= '0;
      in_ss   <= '0;
      data_in <= '0;
    end else begin
      in_s    <= gpio_in_data;
      in_ss   <= in_s;
      data_in <= in_ss;
    end
  end

  // --------------------
  // Plain configuration words
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      out_data <= '0;
      dir_sel  <= '0;
      out_type <= '0;
      int_mask <= '0;
      pos_sel  <= '0;
      neg_sel  <= '0;
    end else if (wr.wr_en) begin
      case (wr.idx)
        pinmux_map_pkg::IDX_GPIO_OUT:
          out_data <= pinmux_bus_pkg::be_merge(out_data, wr.data, wr.be);
        pinmux_map_pkg::IDX_GPIO_DIR:
          dir_sel  <= pinmux_bus_pkg::be_merge(dir_sel, wr.data, wr.be);
        pinmux_map_pkg::IDX_GPIO_TYPE:
          out_type <= pinmux_bus_pkg::be_merge(out_type, wr.data, wr.be);
        pinmux_map_pkg::IDX_GPIO_IMASK:
          int_mask <= pinmux_bus_pkg::be_merge(int_mask, wr.data, wr.be);
        pinmux_map_pkg::IDX_GPIO_POS:
          pos_sel  <= pinmux_bus_pkg::be_merge(pos_sel, wr.data, wr.be);
        pinmux_map_pkg::IDX_GPIO_NEG:
          neg_sel  <= pinmux_bus_pkg::be_merge(neg_sel, wr.data, wr.be);
        default: ;
      endcase
    end
  end

  // --------------------
  // Interrupt status
  // Clear through index 9, set through index 10
  assign istat_hit = wr.commit & (wr.idx == pinmux_map_pkg::IDX_GPIO_ISTAT);
  assign iset_hit  = wr.commit & (wr.idx == pinmux_map_pkg::IDX_GPIO_ISET);
  assign wr_bits   = wr.data & pinmux_bus_pkg::be_mask(wr.be);
  assign stat_clr  = istat_hit ? wr_bits : '0;
  assign stat_set  = gpio_int_event | (iset_hit ? wr_bits : '0);

  // Events posted win over host clears
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      int_stat <= '0;
    end else begin
      int_stat <= stat_set | (int_stat & ~stat_clr);
    end
  end

  // Single request to the global controller
  assign gpio_intr = |(int_stat & int_mask);

  assign cfg_gpio_data_in         = data_in;
  assign cfg_gpio_out_data        = out_data;
  assign cfg_gpio_dir_sel         = dir_sel;
  assign cfg_gpio_out_type        = out_type;
  assign cfg_gpio_posedge_int_sel = pos_sel;
  assign cfg_gpio_negedge_int_sel = neg_sel;

  // Readback, index 10 mirrors the status
  assign rd_words[pinmux_map_pkg::IDX_GPIO_IN]    = data_in;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_OUT]   = out_data;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_DIR]   = dir_sel;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_TYPE]  = out_type;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_ISTAT] = int_stat;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_ISET]  = int_stat;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_IMASK] = int_mask;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_POS]   = pos_sel;
  assign rd_words[pinmux_map_pkg::IDX_GPIO_NEG]   = neg_sel;

endmodule

//--- hw/pinmux_read_path.sv
/* Register read path
   Word select over the map and the registered read data */
`timescale 1ns/1ps

module pinmux_read_path (
  input  logic                      mclk,
  input  logic                      h_reset_n,
  input  logic                      rd_capture,
  input  pinmux_bus_pkg::reg_idx_t  rd_idx,
  input  pinmux_map_pkg::rd_words_t rd_words,
  output pinmux_bus_pkg::reg_data_t rdata
);

  // Selected word, zero past the map
  pinmux_bus_pkg::reg_data_t rd_sel;

  always_comb begin
    rd_sel = '0;
    if (rd_idx < pinmux_map_pkg::NUM_WORDS) begin
      rd_sel = rd_words[rd_idx];
    end
  end

  // --------------------
  // Read data register
  // Loaded the cycle before ack, held until the next read
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      rdata <= '0;
    end else if (rd_capture) begin
      rdata <= rd_sel;
    end
  end

endmodule

//--- hw/pinmux_regs.sv
/* Global and pin-mux register block
   Bus front end, global, interrupt and GPIO registers, read path */
`timescale 1ns/1ps

module pinmux_regs #(
  parameter pinmux_bus_pkg::reg_data_t CHIP_ID_WORD = 32'h8268_1301
) (
  input  logic                       mclk,
  input  logic                       h_reset_n,
  // Register bus
  input  pinmux_bus_pkg::reg_req_t   req,
  output pinmux_bus_pkg::reg_data_t  rdata,
  output logic                       ack,
  // Global control
  output pinmux_map_pkg::rst_ctrl_t  rst_ctrl,
  output logic [9:0]                 cfg_pulse_1us,
  output logic [15:0]                cfg_riscv_ctrl,
  // Interrupts
  input  logic [1:0]                 ext_intr_in,
  input  logic                       usb_intr,
  input  logic                       i2cm_intr,
  input  logic [2:0]                 timer_intr,
  output pinmux_map_pkg::irq_lines_t irq_lines,
  output logic                       soft_irq,
  output pinmux_map_pkg::user_irq_t  user_irq,
  // GPIO
  input  pinmux_bus_pkg::reg_data_t  gpio_in_data,
  input  pinmux_bus_pkg::reg_data_t  gpio_int_event,
  output pinmux_bus_pkg::reg_data_t  cfg_gpio_data_in,
  output pinmux_bus_pkg::reg_data_t  cfg_gpio_out_data,
  output pinmux_bus_pkg::reg_data_t  cfg_gpio_dir_sel,
  output pinmux_bus_pkg::reg_data_t  cfg_gpio_out_type,
  output pinmux_bus_pkg::reg_data_t  cfg_gpio_posedge_int_sel,
  output pinmux_bus_pkg::reg_data_t  cfg_gpio_negedge_int_sel
);

  pinmux_bus_pkg::reg_wr_t   wr;
  logic                      rd_capture;
  pinmux_bus_pkg::reg_idx_t  rd_idx;
  // Each register block drives its own slots
  wire pinmux_map_pkg::rd_words_t rd_words;
  logic                      gpio_intr;
  pinmux_map_pkg::hw_irq_t   hw_irq;

  // Hardware requests, GPIO on top
  assign hw_irq = {gpio_intr, ext_intr_in, usb_intr, i2cm_intr, timer_intr};

  pinmux_bus_front u_bus_front (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .req        (req),
    .ack        (ack),
    .wr         (wr),
    .rd_capture (rd_capture),
    .rd_idx     (rd_idx)
  );

  pinmux_glbl_regs #(
    .CHIP_ID_WORD (CHIP_ID_WORD)
  ) u_glbl_regs (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .wr             (wr),
    .rst_ctrl       (rst_ctrl),
    .cfg_pulse_1us  (cfg_pulse_1us),
    .cfg_riscv_ctrl (cfg_riscv_ctrl),
    .rd_words       (rd_words)
  );

  pinmux_intr_ctrl u_intr_ctrl (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr        (wr),
    .hw_irq    (hw_irq),
    .irq_lines (irq_lines),
    .soft_irq  (soft_irq),
    .user_irq  (user_irq),
    .rd_words  (rd_words)
  );

  pinmux_gpio_regs u_gpio_regs (
    .mclk                     (mclk),
    .h_reset_n                (h_reset_n),
    .wr                       (wr),
    .gpio_in_data             (gpio_in_data),
    .gpio_int_event           (gpio_int_event),
    .cfg_gpio_data_in         (cfg_gpio_data_in),
    .cfg_gpio_out_data        (cfg_gpio_out_data),
    .cfg_gpio_dir_sel         (cfg_gpio_dir_sel),
    .cfg_gpio_out_type        (cfg_gpio_out_type),
    .cfg_gpio_posedge_int_sel (cfg_gpio_posedge_int_sel),
    .cfg_gpio_negedge_int_sel (cfg_gpio_negedge_int_sel),
    .gpio_intr                (gpio_intr),
    .rd_words                 (rd_words)
  );

  pinmux_read_path u_read_path (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .rd_capture (rd_capture),
    .rd_idx     (rd_idx),
    .rd_words   (rd_words),
    .rdata      (rdata)
  );

endmodule

//--- bench/tb_clock_gen.sv
/* Testbench clock and reset
   10 ns mclk, h_reset_n held low for the first cycles */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RST_CYCLES = 3
) (
  output logic mclk,
  output logic h_reset_n
);

  // 100 MHz, half period in ns
  localparam int HALF_PERIOD = 5;

  initial begin
    mclk = 1'b0;
    forever #HALF_PERIOD mclk = ~mclk;
  end

  // Release on a falling edge, clear of the rising edge
  initial begin
    h_reset_n = 1'b0;
    repeat (RST_CYCLES) @(posedge mclk);
    @(negedge mclk);
    h_reset_n = 1'b1;
  end

endmodule

//--- bench/pinmux_props.sv
/* Register bus handshake properties
   Bound into the bus front end, ack timing against cs and reset */
`timescale 1ns/1ps

module pinmux_props (
  input logic mclk,
  input logic h_reset_n,
  input logic cs,
  input logic ack
);

  // Failed properties, summed into the final error count
  int unsigned assert_fails = 0;

  // --------------------
  // Single-cycle ack
  ack_single: assert property (@(posedge mclk) disable iff (!h_reset_n) ack |=> !ack)
    else begin
      assert_fails++;
      $error("ack held high for two cycles");
    end

  // Ack only after a chip select
  ack_after_cs: assert property (@(posedge mclk) disable iff (!h_reset_n) ack |-> $past(cs))
    else begin
      assert_fails++;
      $error("ack raised without a preceding chip select");
    end

  // Quiet bus while in reset
  ack_in_reset: assert property (@(posedge mclk) !h_reset_n |-> !ack)
    else begin
      assert_fails++;
      $error("ack high during reset");
    end

endmodule

//--- bench/tb_pinmux_regs.sv
/* Testbench for the global and pin-mux register block
   Replays bus operations from the input file and checks the results */
`timescale 1ns/1ps

module tb_pinmux_regs;

  localparam pinmux_bus_pkg::reg_data_t CHIP_ID = 32'h8268_1301;
  // Five hex words per record
  localparam int REC_WORDS   = 5;
  localparam int MAX_RECS    = 64;
  localparam int ACK_TIMEOUT = 20;
  localparam int RST_TIMEOUT = 20;
  // Three sync flops plus margin
  localparam int SYNC_WAIT   = 4;

  // --------------------
  // Operation codes
  localparam pinmux_bus_pkg::reg_data_t OP_END   = 32'd0;
  localparam pinmux_bus_pkg::reg_data_t OP_WRITE = 32'd1;
  localparam pinmux_bus_pkg::reg_data_t OP_READ  = 32'd2;
  localparam pinmux_bus_pkg::reg_data_t OP_PINS  = 32'd3;
  localparam pinmux_bus_pkg::reg_data_t OP_PULSE = 32'd4;
  localparam pinmux_bus_pkg::reg_data_t OP_IRQ   = 32'd5;
  localparam pinmux_bus_pkg::reg_data_t OP_RST   = 32'd6;

  logic                       mclk;
  logic                       h_reset_n;
  pinmux_bus_pkg::reg_req_t   req;
  pinmux_bus_pkg::reg_data_t  rdata;
  logic                       ack;
  pinmux_map_pkg::rst_ctrl_t  rst_ctrl;
  logic [9:0]                 cfg_pulse_1us;
  logic [15:0]                cfg_riscv_ctrl;
  logic [1:0]                 ext_intr_in;
  logic                       usb_intr;
  logic                       i2cm_intr;
  logic [2:0]                 timer_intr;
  pinmux_map_pkg::irq_lines_t irq_lines;
  logic                       soft_irq;
  pinmux_map_pkg::user_irq_t  user_irq;
  pinmux_bus_pkg::reg_data_t  gpio_in_data;
  pinmux_bus_pkg::reg_data_t  gpio_int_event;
  pinmux_bus_pkg::reg_data_t  gpio_cfg [6];

  // Stimulus image and error counters
  pinmux_bus_pkg::reg_data_t  stim [REC_WORDS*MAX_RECS];
  int                         mismatches = 0;
  int                         timeouts = 0;
  int                         bad_ops = 0;
  logic                       aborted = 1'b0;

  tb_clock_gen #(.RST_CYCLES(3)) u_clock_gen (.mclk(mclk), .h_reset_n(h_reset_n));

  pinmux_regs #(.CHIP_ID_WORD(CHIP_ID)) UUT (
    .mclk(mclk), .h_reset_n(h_reset_n), .req(req), .rdata(rdata), .ack(ack),
    .rst_ctrl(rst_ctrl), .cfg_pulse_1us(cfg_pulse_1us), .cfg_riscv_ctrl(cfg_riscv_ctrl),
    .ext_intr_in(ext_intr_in), .usb_intr(usb_intr), .i2cm_intr(i2cm_intr),
    .timer_intr(timer_intr), .irq_lines(irq_lines), .soft_irq(soft_irq),
    .user_irq(user_irq), .gpio_in_data(gpio_in_data), .gpio_int_event(gpio_int_event),
    .cfg_gpio_data_in(gpio_cfg[0]), .cfg_gpio_out_data(gpio_cfg[1]),
    .cfg_gpio_dir_sel(gpio_cfg[2]), .cfg_gpio_out_type(gpio_cfg[3]),
    .cfg_gpio_posedge_int_sel(gpio_cfg[4]), .cfg_gpio_negedge_int_sel(gpio_cfg[5])
  );

  // Handshake checks on the bus front end
  bind pinmux_bus_front pinmux_props u_props (
    .mclk(mclk), .h_reset_n(h_reset_n), .cs(req.cs), .ack(ack)
  );

  // --------------------
  // Compare tasks
  task automatic check_data(input string name, input pinmux_bus_pkg::reg_data_t exp,
                            input pinmux_bus_pkg::reg_data_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input pinmux_map_pkg::irq_lines_t exp,
                           input pinmux_map_pkg::irq_lines_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_rst(input string name, input pinmux_map_pkg::rst_ctrl_t exp,
                           input pinmux_map_pkg::rst_ctrl_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Outputs all clear out of reset
  task automatic check_reset_outputs();
    check_data("reset rdata", '0, rdata);
    check_data("reset cfg_pulse_1us", '0, {22'h0, cfg_pulse_1us});
    check_data("reset cfg_riscv_ctrl", '0, {16'h0, cfg_riscv_ctrl});
    for (int i = 0; i < 6; i++) begin
      check_data($sformatf("reset gpio cfg %0d", i), '0, gpio_cfg[i]);
    end
    check_irq("reset irq_lines", '0, irq_lines);
    check_irq("reset soft/user", '0, {12'h000, user_irq, soft_irq});
  endtask

  // Output ports that mirror a register word
  task automatic check_mirror(input string name, input pinmux_bus_pkg::reg_idx_t idx,
                              input pinmux_bus_pkg::reg_data_t exp);
    case (idx)
      pinmux_map_pkg::IDX_GLBL_CFG1: begin
        check_data({name, " pulse_1us"}, {22'h0, exp[9:0]}, {22'h0, cfg_pulse_1us});
        check_data({name, " riscv_ctrl"}, {16'h0, exp[31:16]}, {16'h0, cfg_riscv_ctrl});
      end
      pinmux_map_pkg::IDX_GPIO_IN:   check_data({name, " pin"}, exp, gpio_cfg[0]);
      pinmux_map_pkg::IDX_GPIO_OUT:  check_data({name, " pin"}, exp, gpio_cfg[1]);
      pinmux_map_pkg::IDX_GPIO_DIR:  check_data({name, " pin"}, exp, gpio_cfg[2]);
      pinmux_map_pkg::IDX_GPIO_TYPE: check_data({name, " pin"}, exp, gpio_cfg[3]);
      pinmux_map_pkg::IDX_GPIO_POS:  check_data({name, " pin"}, exp, gpio_cfg[4]);
      pinmux_map_pkg::IDX_GPIO_NEG:  check_data({name, " pin"}, exp, gpio_cfg[5]);
      default: ;
    endcase
  endtask

  // --------------------
  // Bus and pin drivers, all on the falling edge
  task automatic wait_reset();
    int n;
    n = 0;
    while (!h_reset_n && n < RST_TIMEOUT) begin
      @(negedge mclk);
      n++;
    end
    if (!h_reset_n) begin
      timeouts++;
      aborted = 1'b1;
      $display("reset was never released");
    end
  endtask

  // Holds cs through the ack cycle so writes commit, drops it after
  task automatic bus_op(input logic is_wr, input pinmux_bus_pkg::reg_addr_t addr,
                        input pinmux_bus_pkg::reg_data_t data, input pinmux_bus_pkg::reg_be_t be,
                        output pinmux_bus_pkg::reg_data_t rd);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    @(negedge mclk);
    req.cs    = 1'b1;
    req.wr    = is_wr;
    req.addr  = addr;
    req.wdata = data;
    req.be    = be;
    while (!got && n < ACK_TIMEOUT) begin
      @(negedge mclk);
      n++;
      got = ack;
    end
    if (!got) begin
      timeouts++;
      aborted = 1'b1;
      $display("no ack from register bus at address %h", addr);
    end
    rd = rdata;
    @(negedge mclk);
    req = '0;
  endtask

  // One-cycle request, then time for the GPIO to global chain
  task automatic pulse_irq(input logic [6:0] pins, input pinmux_bus_pkg::reg_data_t events);
    @(negedge mclk);
    {ext_intr_in, usb_intr, i2cm_intr, timer_intr} = pins;
    gpio_int_event = events;
    @(negedge mclk);
    {ext_intr_in, usb_intr, i2cm_intr, timer_intr} = '0;
    gpio_int_event = '0;
    @(negedge mclk);
  endtask

  // --------------------
  // Record replay
  initial begin : replay
    int                        rec;
    logic                      done;
    string                     name;
    pinmux_bus_pkg::reg_data_t op;
    pinmux_bus_pkg::reg_data_t addr;
    pinmux_bus_pkg::reg_data_t data;
    pinmux_bus_pkg::reg_data_t be;
    pinmux_bus_pkg::reg_data_t exp;
    pinmux_bus_pkg::reg_data_t rd;
    req            = '0;
    ext_intr_in    = '0;
    usb_intr       = 1'b0;
    i2cm_intr      = 1'b0;
    timer_intr     = '0;
    gpio_in_data   = '0;
    gpio_int_event = '0;
    for (int i = 0; i < REC_WORDS*MAX_RECS; i++) begin
      stim[i] = '0;
    end
    $readmemh("bench/pinmux_input.txt", stim);
    wait_reset();
    if (!aborted) begin
      check_reset_outputs();
    end
    rec  = 0;
    done = 1'b0;
    while (!done && !aborted && rec < MAX_RECS) begin
      op   = stim[rec*REC_WORDS];
      addr = stim[rec*REC_WORDS+1];
      data = stim[rec*REC_WORDS+2];
      be   = stim[rec*REC_WORDS+3];
      exp  = stim[rec*REC_WORDS+4];
      name = $sformatf("record %0d op %0d addr %02h", rec, op, addr[7:0]);
      case (op)
        OP_WRITE: bus_op(1'b1, addr[7:0], data, be[3:0], rd);
        OP_READ: begin
          bus_op(1'b0, addr[7:0], '0, '0, rd);
          if (!aborted) begin
            check_data(name, exp, rd);
            check_mirror(name, addr[6:2], exp);
          end
        end
        OP_PINS: begin
          @(negedge mclk);
          gpio_in_data = data;
          repeat (SYNC_WAIT) @(negedge mclk);
        end
        OP_PULSE: pulse_irq(addr[6:0], data);
        OP_IRQ: begin
          @(negedge mclk);
          check_irq(name, exp[15:0], irq_lines);
          check_irq({name, " soft/user"}, {12'h000, exp[19:16]}, {12'h000, user_irq, soft_irq});
        end
        OP_RST: begin
          @(negedge mclk);
          check_rst(name, exp[8:0], rst_ctrl);
        end
        OP_END: done = 1'b1;
        default: begin
          bad_ops++;
          done = 1'b1;
          $display("unknown operation %0h in record %0d", op, rec);
        end
      endcase
      rec++;
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d bad records, %0d assertions",
             mismatches, timeouts, bad_ops, UUT.u_bus_front.u_props.assert_fails);
    if (mismatches == 0 && timeouts == 0 && bad_ops == 0 &&
        UUT.u_bus_front.u_props.assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- bench/pinmux_input.txt
// Columns: op addr data be expected, all hex; one record per line
// op 1 write, 2 read, 3 set pins, 4 pulse (addr = ext,usb,i2cm,timer), 5 irq, 6 resets, 0 end
2 00 00000000 0 82681301
2 04 00000000 0 00000000
2 10 00000000 0 00000000
2 38 00000000 0 00000000
2 7c 00000000 0 00000000
6 00 00000000 0 00000000
1 04 ffffffff 3 00000000
2 04 00000000 0 0000ffff
6 00 00000000 0 000001ff
1 04 a5a5a5a5 1 00000000
2 04 00000000 0 0000ffa5
6 00 00000000 0 000001d4
1 08 12345678 c 00000000
2 08 00000000 0 12340000
3 00 deadbeef 0 00000000
2 14 00000000 0 deadbeef
1 18 cafef00d f 00000000
2 18 00000000 0 cafef00d
1 2c 00000001 f 00000000
1 0c 000f8000 f 00000000
4 00 00000003 0 00000000
2 24 00000000 0 00000003
1 28 00000f00 f 00000000
2 28 00000000 0 00000f03
2 10 00000000 0 00008000
5 00 00000000 0 00008000
1 24 00000101 f 00000000
2 24 00000000 0 00000e02
1 10 00008000 2 00000000
2 10 00000000 0 00000000
5 00 00000000 0 00000000
1 2c 00000002 f 00000000
1 0c 000f0000 f 00000000
5 00 00000000 0 00000000
2 10 00000000 0 00008000
1 0c 000f8000 f 00000000
5 00 00000000 0 00008000
1 0c 000fffff f 00000000
4 11 00000000 0 00000000
2 10 00000000 0 00009100
5 00 00000000 0 00009100
1 10 00001000 2 00000000
2 10 00000000 0 00008100
1 10 000b0000 4 00000000
2 10 00000000 0 000b8100
5 00 00000000 0 000b8100
1 0c 000effff f 00000000
5 00 00000000 0 000a8100
0 00 00000000 0 00000000

//--- pinmux_regs.f
hw/pinmux_bus_pkg.sv
hw/pinmux_map_pkg.sv
hw/pinmux_bus_front.sv
hw/pinmux_glbl_regs.sv
hw/pinmux_intr_ctrl.sv
hw/pinmux_gpio_regs.sv
hw/pinmux_read_path.sv
hw/pinmux_regs.sv
bench/tb_clock_gen.sv
bench/pinmux_props.sv
bench/tb_pinmux_regs.sv

//--- Makefile
# Verilator build and run for the pinmux register block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_pinmux_regs
FILELIST  := pinmux_regs.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
